//--- fp_alu_pkg.sv
package fp_alu_pkg;

    // single precision only
    localparam int FLEN    = 32;
    localparam int EXP_W   = 8;
    localparam int MAN_W   = 23;
    localparam int CLASS_W = 10;

    localparam logic [6:0] OPCODE_FP    = 7'b1010011;
    localparam logic [6:0] OPCODE_LOAD  = 7'b0000111;  // flw
    localparam logic [6:0] OPCODE_STORE = 7'b0100111;  // fsw

    localparam logic [6:0] FUNCT7_SGNJ   = 7'b0010000;
    localparam logic [6:0] FUNCT7_MINMAX = 7'b0010100;
    localparam logic [6:0] FUNCT7_COMP   = 7'b1010000;
    localparam logic [6:0] FUNCT7_CLASS  = 7'b1110000;  // also fmv.x.w
    localparam logic [6:0] FUNCT7_MVWX   = 7'b1111000;

    // positive quiet nan, top mantissa bit only
    localparam logic [FLEN-1:0] CANONICAL_NAN = 32'h7fc0_0000;

    typedef enum logic [3:0] {
        OP_NONE,
        OP_LOAD,
        OP_STORE,
        OP_FSGNJ,
        OP_FSGNJN,
        OP_FSGNJX,
        OP_FMIN,
        OP_FMAX,
        OP_FEQ,
        OP_FLT,
        OP_FLE,
        OP_FCLASS,
        OP_FMV_X_W,
        OP_FMV_W_X
    } fp_op_e;

    // same bit order as the fflags csr
    typedef struct packed {
        logic nv;
        logic dz;
        logic of;
        logic uf;
        logic nx;
    } fflags_t;

endpackage

//--- fp_op_if.sv
`timescale 1ns/1ps

interface fp_op_if;
    import fp_alu_pkg::*;

    logic            valid;
    fp_op_e          op;
    logic [FLEN-1:0] in1;
    logic [FLEN-1:0] in2;

    modport decode (
        output valid,
        output op,
        output in1,
        output in2
    );

    modport exec (
        input valid,
        input op,
        input in1,
        input in2
    );

endinterface

//--- fp_op_decode.sv
`timescale 1ns/1ps

module fp_op_decode (
    input  logic                          i_valid,
    input  logic [fp_alu_pkg::FLEN-1:0]   i_fp_in1,
    input  logic [fp_alu_pkg::FLEN-1:0]   i_fp_in2,
    input  logic [6:0]                    i_opcode,
    input  logic [2:0]                    i_funct3,
    input  logic [6:0]                    i_funct7,
    fp_op_if.decode                       o_op
);
    import fp_alu_pkg::*;

    fp_op_e op;

    always_comb begin
        op = OP_NONE;
        case (i_opcode)
            OPCODE_LOAD:  op = OP_LOAD;
            OPCODE_STORE: op = OP_STORE;
            OPCODE_FP: begin
                case (i_funct7)
                    FUNCT7_SGNJ: begin
                        case (i_funct3)
                            3'b000:  op = OP_FSGNJ;
                            3'b001:  op = OP_FSGNJN;
                            3'b010:  op = OP_FSGNJX;
                            default: op = OP_NONE;
                        endcase
                    end
                    FUNCT7_MINMAX: begin
                        case (i_funct3)
                            3'b000:  op = OP_FMIN;
                            3'b001:  op = OP_FMAX;
                            default: op = OP_NONE;
                        endcase
                    end
                    FUNCT7_COMP: begin
                        case (i_funct3)
                            3'b010:  op = OP_FEQ;
                            3'b001:  op = OP_FLT;
                            3'b000:  op = OP_FLE;
                            default: op = OP_NONE;
                        endcase
                    end
                    FUNCT7_CLASS: begin
                        case (i_funct3)
                            3'b001:  op = OP_FCLASS;
                            3'b000:  op = OP_FMV_X_W;
                            default: op = OP_NONE;
                        endcase
                    end
                    FUNCT7_MVWX: op = (i_funct3 == 3'b000) ? OP_FMV_W_X : OP_NONE;
                    default:     op = OP_NONE;
                endcase
            end
            default: op = OP_NONE;
        endcase
    end

    assign o_op.valid = i_valid;
    assign o_op.op    = op;
    assign o_op.in1   = i_fp_in1;  // operands pass straight through
    assign o_op.in2   = i_fp_in2;

endmodule

//--- fp_compare.sv
`timescale 1ns/1ps

module fp_compare (
    fp_op_if.exec                         i_op,
    output logic [fp_alu_pkg::FLEN-1:0]   o_minmax,
    output logic                          o_cmp,
    output logic                          o_nv
);
    import fp_alu_pkg::*;

    logic            a_sign;
    logic            b_sign;
    logic [FLEN-2:0] a_mag;
    logic [FLEN-2:0] b_mag;
    logic            a_nan;
    logic            b_nan;
    logic            a_snan;
    logic            b_snan;
    logic            both_zero;
    logic            a_lt_b;
    logic            a_eq_b;
    logic            a_below_b;

    assign a_sign = i_op.in1[FLEN-1];
    assign b_sign = i_op.in2[FLEN-1];
    assign a_mag  = i_op.in1[FLEN-2:0];
    assign b_mag  = i_op.in2[FLEN-2:0];

    assign a_nan  = (a_mag[FLEN-2 -: EXP_W] == '1) && (a_mag[MAN_W-1:0] != '0);
    assign b_nan  = (b_mag[FLEN-2 -: EXP_W] == '1) && (b_mag[MAN_W-1:0] != '0);
    assign a_snan = a_nan && !a_mag[MAN_W-1];
    assign b_snan = b_nan && !b_mag[MAN_W-1];

    assign both_zero = (a_mag == '0) && (b_mag == '0);

    // ieee ordering, +0 and -0 equal
    always_comb begin
        if (a_sign != b_sign) begin
            a_lt_b = a_sign && !both_zero;
        end else if (a_sign) begin
            a_lt_b = b_mag < a_mag;  // both negative, bigger magnitude is smaller
        end else begin
            a_lt_b = a_mag < b_mag;
        end
    end

    assign a_eq_b    = (i_op.in1 == i_op.in2) || both_zero;
    assign a_below_b = a_lt_b || (both_zero && a_sign && !b_sign);  // -0 below +0 for min/max

    always_comb begin
        if (a_nan && b_nan) begin
            o_minmax = CANONICAL_NAN;
        end else if (a_nan) begin
            o_minmax = i_op.in2;
        end else if (b_nan) begin
            o_minmax = i_op.in1;
        end else if (i_op.op == OP_FMAX) begin
            o_minmax = a_below_b ? i_op.in2 : i_op.in1;
        end else begin
            o_minmax = a_below_b ? i_op.in1 : i_op.in2;
        end
    end

    always_comb begin
        o_cmp = 1'b0;
        o_nv  = 1'b0;
        case (i_op.op)
            OP_FMIN, OP_FMAX: o_nv = a_snan || b_snan;
            OP_FEQ: begin
                o_cmp = a_eq_b && !a_nan && !b_nan;
                o_nv  = a_snan || b_snan;  // quiet compare
            end
            OP_FLT: begin
                o_cmp = a_lt_b && !a_nan && !b_nan;
                o_nv  = a_nan || b_nan;
            end
            OP_FLE: begin
                o_cmp = (a_lt_b || a_eq_b) && !a_nan && !b_nan;
                o_nv  = a_nan || b_nan;
            end
            default: begin
                o_cmp = 1'b0;
                o_nv  = 1'b0;
            end
        endcase
    end

endmodule

//--- fp_classify.sv
`timescale 1ns/1ps

module fp_classify (
    fp_op_if.exec                             i_op,
    output logic [fp_alu_pkg::CLASS_W-1:0]    o_class
);
    import fp_alu_pkg::*;

    logic             sign;
    logic [EXP_W-1:0] exp_f;
    logic [MAN_W-1:0] man_f;
    logic             is_inf;
    logic             is_nan;
    logic             is_norm;
    logic             is_sub;
    logic             is_zero;

    assign sign  = i_op.in1[FLEN-1];
    assign exp_f = i_op.in1[FLEN-2 -: EXP_W];
    assign man_f = i_op.in1[MAN_W-1:0];

    assign is_inf  = (exp_f == '1) && (man_f == '0);
    assign is_nan  = (exp_f == '1) && (man_f != '0);
    assign is_norm = (exp_f != '0) && (exp_f != '1);
    assign is_sub  = (exp_f == '0) && (man_f != '0);
    assign is_zero = (exp_f == '0) && (man_f == '0);

    // bit 0 is -inf, bit 9 is quiet nan
    assign o_class = {
        is_nan && man_f[MAN_W-1],
        is_nan && !man_f[MAN_W-1],
        !sign && is_inf,
        !sign && is_norm,
        !sign && is_sub,
        !sign && is_zero,
        sign && is_zero,
        sign && is_sub,
        sign && is_norm,
        sign && is_inf
    };

endmodule

//--- fp_result_stage.sv
`timescale 1ns/1ps

module fp_result_stage (
    input  logic                              i_clk,
    input  logic                              i_reset,
    fp_op_if.exec                             i_op,
    input  logic [fp_alu_pkg::FLEN-1:0]       i_minmax,
    input  logic                              i_cmp,
    input  logic                              i_nv,
    input  logic [fp_alu_pkg::CLASS_W-1:0]    i_class,
    output logic                              o_valid,
    output logic [fp_alu_pkg::FLEN-1:0]       o_result,
    output fp_alu_pkg::fflags_t               o_fflags,
    output logic                              o_fp_reg_write
);
    import fp_alu_pkg::*;

    logic [FLEN-2:0] in1_mag;
    logic [FLEN-1:0] sel_result;
    logic [FLEN-1:0] next_result;
    logic            next_reg_write;
    logic            is_move;
    logic            sel_nan;
    fflags_t         next_fflags;

    assign in1_mag = i_op.in1[FLEN-2:0];

    always_comb begin
        sel_result     = '0;
        next_reg_write = 1'b0;
        case (i_op.op)
            OP_FSGNJ: begin
                sel_result     = {i_op.in2[FLEN-1], in1_mag};
                next_reg_write = 1'b1;
            end
            OP_FSGNJN: begin
                sel_result     = {~i_op.in2[FLEN-1], in1_mag};
                next_reg_write = 1'b1;
            end
            OP_FSGNJX: begin
                sel_result     = {i_op.in1[FLEN-1] ^ i_op.in2[FLEN-1], in1_mag};
                next_reg_write = 1'b1;
            end
            OP_FMIN, OP_FMAX: begin
                sel_result     = i_minmax;
                next_reg_write = 1'b1;
            end
            OP_FEQ, OP_FLT, OP_FLE: sel_result = {{(FLEN-1){1'b0}}, i_cmp};
            OP_FCLASS:              sel_result = {{(FLEN-CLASS_W){1'b0}}, i_class};
            OP_FMV_X_W:             sel_result = i_op.in1;  // to integer file
            OP_FMV_W_X: begin
                sel_result     = i_op.in1;
                next_reg_write = 1'b1;
            end
            OP_LOAD: next_reg_write = 1'b1;
            default: begin
                sel_result     = '0;
                next_reg_write = 1'b0;
            end
        endcase
    end

    // moves keep nan payloads
    assign is_move     = (i_op.op == OP_FMV_X_W) || (i_op.op == OP_FMV_W_X);
    assign sel_nan     = (sel_result[FLEN-2 -: EXP_W] == '1) && (sel_result[MAN_W-1:0] != '0);
    assign next_result = (sel_nan && !is_move) ? CANONICAL_NAN : sel_result;
    assign next_fflags = '{nv: i_nv, dz: 1'b0, of: 1'b0, uf: 1'b0, nx: 1'b0};

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_valid        <= 1'b0;
            o_result       <= '0;
            o_fflags       <= '0;
            o_fp_reg_write <= 1'b0;
        end else begin
            o_valid <= i_op.valid;
            if (i_op.valid) begin  // hold last result otherwise
                o_result       <= next_result;
                o_fflags       <= next_fflags;
                o_fp_reg_write <= next_reg_write;
            end
        end
    end

endmodule

//--- fp_alu_top.sv
`timescale 1ns/1ps

module fp_alu_top (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  logic                          i_valid,
    input  logic [fp_alu_pkg::FLEN-1:0]   i_fp_in1,
    input  logic [fp_alu_pkg::FLEN-1:0]   i_fp_in2,
    input  logic [6:0]                    i_opcode,
    input  logic [2:0]                    i_funct3,
    input  logic [6:0]                    i_funct7,
    output logic                          o_valid,
    output logic [fp_alu_pkg::FLEN-1:0]   o_result,
    output logic [4:0]                    o_fflags,
    output logic                          o_fp_reg_write
);

    logic [fp_alu_pkg::FLEN-1:0]    minmax;
    logic                           cmp;
    logic                           nv;
    logic [fp_alu_pkg::CLASS_W-1:0] class_vec;

    fp_op_if op_if ();

    fp_op_decode u_decode (
        .i_valid   (i_valid),
        .i_fp_in1  (i_fp_in1),
        .i_fp_in2  (i_fp_in2),
        .i_opcode  (i_opcode),
        .i_funct3  (i_funct3),
        .i_funct7  (i_funct7),
        .o_op      (op_if.decode)
    );

    fp_compare u_compare (
        .i_op      (op_if.exec),
        .o_minmax  (minmax),
        .o_cmp     (cmp),
        .o_nv      (nv)
    );

    fp_classify u_classify (
        .i_op      (op_if.exec),
        .o_class   (class_vec)
    );

    // only registered stage
    fp_result_stage u_result (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_op           (op_if.exec),
        .i_minmax       (minmax),
        .i_cmp          (cmp),
        .i_nv           (nv),
        .i_class        (class_vec),
        .o_valid        (o_valid),
        .o_result       (o_result),
        .o_fflags       (o_fflags),
        .o_fp_reg_write (o_fp_reg_write)
    );

endmodule

//--- fp_alu_sva.sv
`timescale 1ns/1ps

module fp_alu_sva (
    input logic                        i_clk,
    input logic                        i_reset,
    input logic                        i_valid,
    input logic [fp_alu_pkg::FLEN-1:0] i_fp_in1,
    input logic [fp_alu_pkg::FLEN-1:0] i_fp_in2,
    input logic [6:0]                  i_opcode,
    input logic [2:0]                  i_funct3,
    input logic [6:0]                  i_funct7,
    input logic                        o_valid,
    input logic [fp_alu_pkg::FLEN-1:0] o_result,
    input logic [4:0]                  o_fflags,
    input logic                        o_fp_reg_write
);
    import fp_alu_pkg::*;

    logic            p_valid;
    logic [FLEN-1:0] p_in1;
    logic [FLEN-1:0] p_in2;
    logic [6:0]      p_opcode;
    logic [2:0]      p_funct3;
    logic [6:0]      p_funct7;
    logic [FLEN+1:0] exp_out;  // nv, reg write, result

    function automatic logic nan_of(input logic [31:0] x);
        return (x[30:23] == 8'hff) && (x[22:0] != '0);
    endfunction

    function automatic logic snan_of(input logic [31:0] x);
        return nan_of(x) && !x[22];
    endfunction

    // strict ieee less-than where zeros compare equal
    function automatic logic ordered_below(input logic [31:0] a, input logic [31:0] b);
        if (a[30:0] == '0 && b[30:0] == '0) begin
            return 1'b0;
        end
        if (a[31] != b[31]) begin
            return a[31];
        end
        return a[31] ? (a[30:0] > b[30:0]) : (a[30:0] < b[30:0]);
    endfunction

    function automatic logic same_value(input logic [31:0] a, input logic [31:0] b);
        return (a == b) || (a[30:0] == '0 && b[30:0] == '0);
    endfunction

    function automatic logic [31:0] min_max(input logic [31:0] a, input logic [31:0] b,
                                            input logic want_max);
        logic a_first;
        if (nan_of(a) && nan_of(b)) begin
            return CANONICAL_NAN;
        end
        if (nan_of(a)) begin
            return b;
        end
        if (nan_of(b)) begin
            return a;
        end
        a_first = ordered_below(a, b) || (a[31] && !b[31] && a[30:0] == '0 && b[30:0] == '0);
        return (a_first ^ want_max) ? a : b;
    endfunction

    function automatic logic [9:0] class_of(input logic [31:0] x);
        logic [9:0] c;
        c = '0;
        if (nan_of(x))
            c[x[22] ? 9 : 8] = 1'b1;
        else if (x[30:23] == 8'hff)
            c[x[31] ? 0 : 7] = 1'b1;
        else if (x[30:23] != '0)
            c[x[31] ? 1 : 6] = 1'b1;
        else if (x[22:0] != '0)
            c[x[31] ? 2 : 5] = 1'b1;  // subnormal
        else
            c[x[31] ? 3 : 4] = 1'b1;
        return c;
    endfunction

    function automatic logic [33:0] expect_out(input logic [6:0] opc, input logic [2:0] f3,
                                               input logic [6:0] f7, input logic [31:0] a,
                                               input logic [31:0] b);
        logic [31:0] res;
        logic        nv;
        logic        rw;
        logic        move;
        logic        any_nan;
        logic        any_snan;
        res      = '0;
        nv       = 1'b0;
        rw       = 1'b0;
        move     = 1'b0;
        any_nan  = nan_of(a) || nan_of(b);
        any_snan = snan_of(a) || snan_of(b);
        if (opc == OPCODE_LOAD) begin
            rw = 1'b1;
        end else if (opc == OPCODE_FP) begin
            case (f7)
                FUNCT7_SGNJ: begin
                    if (f3 <= 3'd2) begin
                        rw = 1'b1;
                        case (f3)
                            3'd0:    res = {b[31], a[30:0]};
                            3'd1:    res = {~b[31], a[30:0]};
                            default: res = {a[31] ^ b[31], a[30:0]};
                        endcase
                    end
                end
                FUNCT7_MINMAX: begin
                    if (f3 <= 3'd1) begin
                        rw  = 1'b1;
                        nv  = any_snan;
                        res = min_max(a, b, f3[0]);
                    end
                end
                FUNCT7_COMP: begin
                    case (f3)
                        3'd2: begin
                            res = {31'b0, !any_nan && same_value(a, b)};
                            nv  = any_snan;
                        end
                        3'd1: begin
                            res = {31'b0, !any_nan && ordered_below(a, b)};
                            nv  = any_nan;
                        end
                        3'd0: begin
                            res = {31'b0, !any_nan && (ordered_below(a, b) || same_value(a, b))};
                            nv  = any_nan;
                        end
                        default: res = '0;
                    endcase
                end
                FUNCT7_CLASS: begin
                    if (f3 == 3'd1) begin
                        res = {22'b0, class_of(a)};
                    end else if (f3 == 3'd0) begin
                        res  = a;
                        move = 1'b1;
                    end
                end
                FUNCT7_MVWX: begin
                    if (f3 == 3'd0) begin
                        res  = a;
                        rw   = 1'b1;
                        move = 1'b1;
                    end
                end
                default: res = '0;
            endcase
        end
        if (!move && nan_of(res)) begin
            res = CANONICAL_NAN;
        end
        return {nv, rw, res};
    endfunction

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            p_valid <= 1'b0;
        end else begin
            p_valid <= i_valid;
        end
        p_in1    <= i_fp_in1;
        p_in2    <= i_fp_in2;
        p_opcode <= i_opcode;
        p_funct3 <= i_funct3;
        p_funct7 <= i_funct7;
    end

    assign exp_out = expect_out(p_opcode, p_funct3, p_funct7, p_in1, p_in2);

    a_reset_clears: assert property (@(posedge i_clk)
        $past(i_reset) |-> (o_valid == 1'b0 && o_fp_reg_write == 1'b0
                            && o_fflags == '0 && o_result == '0))
        else begin
            $error("outputs not cleared by reset");
            tb_fp_alu.assert_fails++;
        end

    a_valid_latency: assert property (@(posedge i_clk) disable iff (i_reset)
        o_valid == p_valid)
        else begin
            $error("o_valid %b, one cycle after i_valid %b", $sampled(o_valid),
                   $sampled(p_valid));
            tb_fp_alu.assert_fails++;
        end

    a_outputs_hold: assert property (@(posedge i_clk) disable iff (i_reset)
        !o_valid |-> ($stable(o_result) && $stable(o_fflags) && $stable(o_fp_reg_write)))
        else begin
            $error("outputs changed while o_valid low");
            tb_fp_alu.assert_fails++;
        end

    a_result: assert property (@(posedge i_clk) disable iff (i_reset)
        p_valid |-> o_result == exp_out[31:0])
        else begin
            $error("result %h, expected %h", $sampled(o_result), $sampled(exp_out[31:0]));
            tb_fp_alu.assert_fails++;
        end

    a_flags: assert property (@(posedge i_clk) disable iff (i_reset)
        p_valid |-> o_fflags == {exp_out[33], 4'b0000})
        else begin
            $error("fflags %b, expected nv %b only", $sampled(o_fflags),
                   $sampled(exp_out[33]));
            tb_fp_alu.assert_fails++;
        end

    a_reg_write: assert property (@(posedge i_clk) disable iff (i_reset)
        p_valid |-> o_fp_reg_write == exp_out[32])
        else begin
            $error("reg write %b, expected %b", $sampled(o_fp_reg_write),
                   $sampled(exp_out[32]));
            tb_fp_alu.assert_fails++;
        end

endmodule

//--- tb_fp_alu.sv
`timescale 1ns/1ps

module tb_fp_alu;
    import fp_alu_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int SEED         = 42476;
    localparam int N_OPERANDS   = 10;
    localparam int N_RANDOM     = 16;
    localparam int DRAIN_LIMIT  = 8;
    // stimulus cycles of all tests plus drain allowance
    localparam int STIM_CYCLES  = RESET_CYCLES + 29 + 5 * (N_RANDOM + 2)
                                + 5 * N_OPERANDS * N_OPERANDS + 10 + 5
                                + 6 * (DRAIN_LIMIT + 1);
    localparam int WATCHDOG_NS  = (STIM_CYCLES + 100) * CLK_PERIOD;

    logic        clk;
    logic        reset;
    logic        valid;
    logic [31:0] fp_in1;
    logic [31:0] fp_in2;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic        o_valid;
    logic [31:0] o_result;
    logic [4:0]  o_fflags;
    logic        o_fp_reg_write;

    int          assert_fails;  // bumped by the bound checker
    int          fails_at_start;
    int          tests_run;
    int          failed_tests;
    int          drain_timeouts;
    string       cur_test;
    logic [31:0] operand_set [N_OPERANDS];
    logic [31:0] class_set [10];

    fp_alu_top i_fp_alu_top (
        .i_clk          (clk),
        .i_reset        (reset),
        .i_valid        (valid),
        .i_fp_in1       (fp_in1),
        .i_fp_in2       (fp_in2),
        .i_opcode       (opcode),
        .i_funct3       (funct3),
        .i_funct7       (funct7),
        .o_valid        (o_valid),
        .o_result       (o_result),
        .o_fflags       (o_fflags),
        .o_fp_reg_write (o_fp_reg_write)
    );

    bind fp_alu_top fp_alu_sva u_sva (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(assert_fails) begin
        if (assert_fails != 0) begin
            $display("** Error: time %0t: wrong output during %s", $time, cur_test);
        end
    end

    task automatic drive_op(input logic [6:0] opc, input logic [2:0] f3, input logic [6:0] f7,
                            input logic [31:0] a, input logic [31:0] b);
        @(posedge clk);
        valid  <= 1'b1;
        opcode <= opc;
        funct3 <= f3;
        funct7 <= f7;
        fp_in1 <= a;
        fp_in2 <= b;
    endtask

    // fresh operands while idle, held outputs must not follow them
    task automatic drive_idle();
        @(posedge clk);
        valid  <= 1'b0;
        opcode <= OPCODE_FP;
        funct3 <= 3'd0;
        funct7 <= FUNCT7_MVWX;
        fp_in1 <= $urandom();
        fp_in2 <= $urandom();
    endtask

    task automatic drive_random_op();
        logic [31:0] a;
        logic [31:0] b;
        a = $urandom();
        b = $urandom();
        case ($urandom_range(0, 5))
            0: drive_op(OPCODE_FP, 3'($urandom_range(0, 2)), FUNCT7_SGNJ, a, b);
            1: drive_op(OPCODE_FP, 3'($urandom_range(0, 1)), FUNCT7_MINMAX, a, b);
            2: drive_op(OPCODE_FP, 3'($urandom_range(0, 2)), FUNCT7_COMP, a, b);
            3: drive_op(OPCODE_FP, 3'($urandom_range(0, 1)), FUNCT7_CLASS, a, b);
            4: drive_op(OPCODE_FP, 3'd0, FUNCT7_MVWX, a, b);
            default: drive_op(OPCODE_LOAD, 3'd0, 7'd0, a, b);
        endcase
    endtask

    task automatic start_test(input string name);
        cur_test       = name;
        fails_at_start = assert_fails;
    endtask

    // let the last result leave the output register, then report
    task automatic end_test();
        int n;
        int fails;
        drive_idle();
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (o_valid && n < DRAIN_LIMIT);
        fails = assert_fails - fails_at_start;
        if (o_valid) begin
            $display("o_valid stayed high %0d cycles after the last input of %s", n, cur_test);
            drain_timeouts++;
            fails++;
        end
        tests_run++;
        if (fails > 0) begin
            failed_tests++;
        end
        $display("test %s done, %0d failures", cur_test, fails);
    endtask

    task automatic test_reset_latency();
        int i;
        start_test("reset_and_latency");
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        for (i = 0; i < 4; i++) begin
            drive_random_op();  // back to back
        end
        drive_idle();
        for (i = 0; i < 24; i++) begin
            if ($urandom_range(0, 1) == 1) begin
                drive_random_op();
            end else begin
                drive_idle();
            end
        end
        end_test();
    endtask

    task automatic test_sign_moves();
        int          i;
        int          f3;
        logic [31:0] a;
        logic [31:0] b;
        start_test("sign_inject_moves");
        for (i = 0; i < N_RANDOM + 2; i++) begin
            a = $urandom();
            b = $urandom();
            if (i == N_RANDOM) a = 32'h7f80_0001;      // snan payload
            if (i == N_RANDOM + 1) a = 32'hffc1_2345;
            for (f3 = 0; f3 < 3; f3++) begin
                drive_op(OPCODE_FP, 3'(f3), FUNCT7_SGNJ, a, b);
            end
            drive_op(OPCODE_FP, 3'd0, FUNCT7_CLASS, a, b);
            drive_op(OPCODE_FP, 3'd0, FUNCT7_MVWX, a, b);
        end
        end_test();
    endtask

    task automatic test_min_max();
        int i;
        int j;
        start_test("min_max");
        for (i = 0; i < N_OPERANDS; i++) begin
            for (j = 0; j < N_OPERANDS; j++) begin
                drive_op(OPCODE_FP, 3'd0, FUNCT7_MINMAX, operand_set[i], operand_set[j]);
                drive_op(OPCODE_FP, 3'd1, FUNCT7_MINMAX, operand_set[i], operand_set[j]);
            end
        end
        end_test();
    endtask

    task automatic test_compare();
        int i;
        int j;
        int f3;
        start_test("compare");
        for (i = 0; i < N_OPERANDS; i++) begin
            for (j = 0; j < N_OPERANDS; j++) begin
                for (f3 = 0; f3 < 3; f3++) begin
                    drive_op(OPCODE_FP, 3'(f3), FUNCT7_COMP, operand_set[i], operand_set[j]);
                end
            end
        end
        end_test();
    endtask

    task automatic test_classify();
        int i;
        start_test("classify");
        for (i = 0; i < 10; i++) begin
            drive_op(OPCODE_FP, 3'd1, FUNCT7_CLASS, class_set[i], $urandom());
        end
        end_test();
    endtask

    task automatic test_load_store();
        start_test("load_store_unknown");
        drive_op(OPCODE_LOAD, 3'd2, 7'd0, $urandom(), $urandom());
        drive_op(OPCODE_STORE, 3'd2, 7'd0, $urandom(), $urandom());
        drive_op(OPCODE_FP, 3'd0, 7'b1111111, 32'h7f80_0001, 32'h3f80_0000);
        drive_op(OPCODE_FP, 3'd3, FUNCT7_SGNJ, 32'h7fc0_0000, 32'h0);
        drive_op(7'b0110011, 3'd0, FUNCT7_MINMAX, $urandom(), $urandom());
        end_test();
    endtask

    initial begin
        void'($urandom(SEED));
        clk            = 1'b0;
        reset          = 1'b1;
        valid          = 1'b0;
        fp_in1         = '0;
        fp_in2         = '0;
        opcode         = '0;
        funct3         = '0;
        funct7         = '0;
        assert_fails   = 0;
        tests_run      = 0;
        failed_tests   = 0;
        drain_timeouts = 0;
        cur_test       = "reset";
        // +-0, +-inf, normals, subnormal, quiet and signaling nans
        operand_set = '{32'h0000_0000, 32'h8000_0000, 32'h7f80_0000, 32'hff80_0000,
                        32'h3f80_0000, 32'hc000_0000, 32'h0000_0001, 32'h7fc0_0123,
                        32'h7f80_0001, 32'hffc0_0000};
        class_set = '{32'hff80_0000, 32'hbf80_0000, 32'h807f_ffff, 32'h8000_0000,
                      32'h0000_0000, 32'h0000_0001, 32'h3f80_0000, 32'h7f80_0000,
                      32'h7fa0_0000, 32'h7fc0_0000};

        test_reset_latency();
        test_sign_moves();
        test_min_max();
        test_compare();
        test_classify();
        test_load_store();

        $display("tests run %0d, tests failed %0d, assertion failures %0d, drain timeouts %0d",
                 tests_run, failed_tests, assert_fails, drain_timeouts);
        if (failed_tests == 0 && assert_fails == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- filelist.f
fp_alu_pkg.sv
fp_op_if.sv
fp_op_decode.sv
fp_compare.sv
fp_classify.sv
fp_result_stage.sv
fp_alu_top.sv
fp_alu_sva.sv
tb_fp_alu.sv

//--- Bender.yml
package:
  name: fp_alu

sources:
  - fp_alu_pkg.sv
  - fp_op_if.sv
  - fp_op_decode.sv
  - fp_compare.sv
  - fp_classify.sv
  - fp_result_stage.sv
  - fp_alu_top.sv
  - target: simulation
    files:
      - fp_alu_sva.sv
      - tb_fp_alu.sv
